// File: flist.f
+incdir+src
src/coreTypes.sv
src/regFile.sv
src/csrFile.sv
src/regReadStage.sv
src/regReadTop.sv
sim/regReadTb_assert.sv
sim/regReadTb.sv

// File: sim/regReadTb.sv
// inputs change 2 ns after the rising edge and the run stops with a timeout after 400 cycles
`include "core_defines.svh"

module regReadTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CycleLimit = 400;

    logic clk;
    logic rst;
    logic stall;
    logic flush;
    logic inValid;
    coreTypes::opKind_t inOp;
    logic inCsrReadEnable;
    coreTypes::word_t inPc;
    coreTypes::word_t inInsn;
    coreTypes::csrAddr_t inCsrAddr;
    coreTypes::regAddr_t inSrcRegAddr1;
    coreTypes::regAddr_t inSrcRegAddr2;
    coreTypes::regAddr_t inDstRegAddr;
    logic inTrapValid;
    coreTypes::excCode_t inTrapCause;
    coreTypes::word_t inTrapValue;
    logic regWriteEnable;
    coreTypes::regAddr_t regWriteAddr;
    coreTypes::word_t regWriteData;
    logic csrWriteEnable;
    coreTypes::csrAddr_t csrWriteAddr;
    coreTypes::word_t csrWriteData;
    logic outValid;
    coreTypes::opKind_t outOp;
    coreTypes::word_t outPc;
    coreTypes::word_t outInsn;
    coreTypes::csrAddr_t outCsrAddr;
    coreTypes::word_t outSrcCsrValue;
    coreTypes::regAddr_t outSrcRegAddr1;
    coreTypes::regAddr_t outSrcRegAddr2;
    coreTypes::regAddr_t outDstRegAddr;
    coreTypes::word_t outSrcRegValue1;
    coreTypes::word_t outSrcRegValue2;
    logic outTrapValid;
    coreTypes::excCode_t outTrapCause;
    coreTypes::word_t outTrapValue;

    coreTypes::word_t regModel [`REG_COUNT]; // entry 0 is never written
    logic [31:0] lcgState = 32'h34c6;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    regReadTop regReadTop_i (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("timeout: the tests did not finish within %0d cycles", CycleLimit);
            $display("sim failed");
            $finish;
        end
    end

    function automatic coreTypes::word_t nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic coreTypes::regAddr_t randomReg();
        return coreTypes::regAddr_t'(nextRandom() >> 16); // upper bits because the low ones cycle fast
    endfunction

    task automatic compareWord(string name, coreTypes::word_t expected, coreTypes::word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic compareRegAddr(string name, coreTypes::regAddr_t expected,
            coreTypes::regAddr_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic compareCsrAddr(string name, coreTypes::csrAddr_t expected,
            coreTypes::csrAddr_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic compareExc(string name, coreTypes::excCode_t expected,
            coreTypes::excCode_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic compareOp(string name, coreTypes::opKind_t expected,
            coreTypes::opKind_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic compareBit(string name, logic expected, logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic clearInputs();
        stall = 1'b0;
        flush = 1'b0;
        inValid = 1'b0;
        inOp = coreTypes::OpAlu;
        inCsrReadEnable = 1'b0;
        inPc = '0;
        inInsn = '0;
        inCsrAddr = '0;
        inSrcRegAddr1 = '0;
        inSrcRegAddr2 = '0;
        inDstRegAddr = '0;
        inTrapValid = 1'b0;
        inTrapCause = coreTypes::InsnMisaligned;
        inTrapValue = '0;
        regWriteEnable = 1'b0;
        regWriteAddr = '0;
        regWriteData = '0;
        csrWriteEnable = 1'b0;
        csrWriteAddr = '0;
        csrWriteData = '0;
    endtask

    // puts a fresh instruction without an incoming trap on the decode side
    task automatic issue(coreTypes::regAddr_t src1, coreTypes::regAddr_t src2,
            coreTypes::csrAddr_t csrAddr, logic csrEnable);
        inValid = 1'b1;
        inOp = coreTypes::opKind_t'(nextRandom() % 32'd6);
        inPc = nextRandom() & 32'hFFFF_FFFC;
        inInsn = nextRandom();
        inCsrReadEnable = csrEnable;
        inCsrAddr = csrAddr;
        inSrcRegAddr1 = src1;
        inSrcRegAddr2 = src2;
        inDstRegAddr = randomReg();
        inTrapValid = 1'b0;
        inTrapCause = coreTypes::Breakpoint; // stale fields with valid low must be cleared
        inTrapValue = nextRandom();
    endtask

    task automatic writeReg(coreTypes::regAddr_t addr, coreTypes::word_t data);
        regWriteEnable = 1'b1;
        regWriteAddr = addr;
        regWriteData = data;
        nextCycle();
        regWriteEnable = 1'b0;
        if (addr != '0) regModel[addr] = data; // x0 stays zero
    endtask

    task automatic writeCsr(coreTypes::csrAddr_t addr, coreTypes::word_t data);
        csrWriteEnable = 1'b1;
        csrWriteAddr = addr;
        csrWriteData = data;
        nextCycle();
        csrWriteEnable = 1'b0;
    endtask

    task automatic checkFields(logic valid, coreTypes::opKind_t op, coreTypes::word_t pc,
            coreTypes::word_t insn, coreTypes::csrAddr_t csrAddr, coreTypes::word_t csrValue,
            coreTypes::regAddr_t src1, coreTypes::regAddr_t src2, coreTypes::regAddr_t dst,
            coreTypes::word_t value1, coreTypes::word_t value2, logic trapValid,
            coreTypes::excCode_t trapCause, coreTypes::word_t trapValue);
        compareBit("outValid", valid, outValid);
        compareOp("outOp", op, outOp);
        compareWord("outPc", pc, outPc);
        compareWord("outInsn", insn, outInsn);
        compareCsrAddr("outCsrAddr", csrAddr, outCsrAddr);
        compareWord("outSrcCsrValue", csrValue, outSrcCsrValue);
        compareRegAddr("outSrcRegAddr1", src1, outSrcRegAddr1);
        compareRegAddr("outSrcRegAddr2", src2, outSrcRegAddr2);
        compareRegAddr("outDstRegAddr", dst, outDstRegAddr);
        compareWord("outSrcRegValue1", value1, outSrcRegValue1);
        compareWord("outSrcRegValue2", value2, outSrcRegValue2);
        compareBit("outTrapValid", trapValid, outTrapValid);
        compareExc("outTrapCause", trapCause, outTrapCause);
        compareWord("outTrapValue", trapValue, outTrapValue);
    endtask

    // the decode inputs are still the ones sampled at the last edge
    task automatic checkLoaded(coreTypes::word_t csrValue, logic trapValid,
            coreTypes::excCode_t trapCause, coreTypes::word_t trapValue);
        checkFields(inValid, inOp, inPc, inInsn, inCsrAddr, csrValue, inSrcRegAddr1,
            inSrcRegAddr2, inDstRegAddr, regModel[inSrcRegAddr1], regModel[inSrcRegAddr2],
            trapValid, trapCause, trapValue);
    endtask

    task automatic checkNoTrap(coreTypes::word_t csrValue);
        checkLoaded(csrValue, 1'b0, coreTypes::InsnMisaligned, '0);
    endtask

    task automatic checkCleared();
        checkFields(1'b0, coreTypes::OpAlu, '0, '0, '0, '0, '0, '0, '0, '0, '0, 1'b0,
            coreTypes::InsnMisaligned, '0);
    endtask

    task automatic readRegisters();
        coreTypes::word_t oldValue;
        for (int i = 0; i < 8; i++) writeReg(randomReg(), nextRandom());
        writeReg('0, nextRandom());
        for (int i = 0; i < 6; i++) begin
            issue(randomReg(), randomReg(), '0, 1'b0);
            nextCycle();
            checkNoTrap('0);
        end
        issue('0, '0, '0, 1'b0); // x0 after a write to it
        nextCycle();
        checkNoTrap('0);
        oldValue = regModel[5];
        issue(5'd5, 5'd5, '0, 1'b0);
        regWriteEnable = 1'b1; // same-cycle write must not be seen yet
        regWriteAddr = 5'd5;
        regWriteData = ~oldValue;
        nextCycle();
        regWriteEnable = 1'b0;
        checkNoTrap('0);
        regModel[5] = ~oldValue;
        issue(5'd5, 5'd0, '0, 1'b0);
        nextCycle();
        checkNoTrap('0);
        clearInputs();
    endtask

    task automatic readCsrs();
        coreTypes::csrAddr_t addrs [4];
        coreTypes::word_t values [4];
        addrs[0] = `CSR_MSCRATCH;
        addrs[1] = `CSR_MTVEC;
        addrs[2] = `CSR_MEPC;
        addrs[3] = `CSR_MCAUSE;
        for (int i = 0; i < 4; i++) begin
            values[i] = nextRandom();
            writeCsr(addrs[i], values[i]);
        end
        writeCsr(`CSR_MHARTID, nextRandom()); // read-only so the write must be dropped
        for (int i = 0; i < 4; i++) begin
            issue('0, '0, addrs[i], 1'b1);
            nextCycle();
            checkNoTrap(values[i]);
        end
        issue('0, '0, `CSR_MHARTID, 1'b1);
        nextCycle();
        checkNoTrap('0);
        issue('0, '0, `CSR_MSCRATCH, 1'b0); // a disabled read returns zero
        nextCycle();
        checkNoTrap('0);
        clearInputs();
    endtask

    task automatic trapIllegalCsr();
        issue('0, '0, 12'h7C0, 1'b1);
        nextCycle();
        checkLoaded('0, 1'b1, coreTypes::IllegalInsn, inInsn);
        issue('0, '0, 12'h7C0, 1'b1);
        inTrapValid = 1'b1; // an earlier ecall outranks the illegal read
        inTrapCause = coreTypes::Ecall;
        inTrapValue = nextRandom();
        nextCycle();
        checkLoaded('0, 1'b1, coreTypes::Ecall, inTrapValue);
        issue('0, '0, 12'h7C0, 1'b0);
        nextCycle();
        checkNoTrap('0);
        clearInputs();
    endtask

    task automatic holdOnStall();
        coreTypes::opKind_t op;
        coreTypes::word_t pc;
        coreTypes::word_t insn;
        coreTypes::regAddr_t src1;
        coreTypes::regAddr_t src2;
        coreTypes::regAddr_t dst;
        issue(randomReg(), randomReg(), '0, 1'b0);
        nextCycle();
        checkNoTrap('0);
        op = inOp;
        pc = inPc;
        insn = inInsn;
        src1 = inSrcRegAddr1;
        src2 = inSrcRegAddr2;
        dst = inDstRegAddr;
        stall = 1'b1;
        for (int i = 0; i < 4; i++) begin
            issue(randomReg(), randomReg(), '0, 1'b0);
            nextCycle();
            checkFields(1'b1, op, pc, insn, '0, '0, src1, src2, dst, regModel[src1],
                regModel[src2], 1'b0, coreTypes::InsnMisaligned, '0);
        end
        stall = 1'b0; // the held instruction loads at the next edge
        nextCycle();
        checkNoTrap('0);
        clearInputs();
    endtask

    task automatic clearOnFlush();
        issue(randomReg(), randomReg(), '0, 1'b0);
        nextCycle();
        checkNoTrap('0);
        flush = 1'b1;
        nextCycle();
        checkCleared();
        flush = 1'b0;
        issue(randomReg(), randomReg(), '0, 1'b0);
        nextCycle();
        checkNoTrap('0);
        stall = 1'b1;
        flush = 1'b1;
        nextCycle();
        checkCleared();
        clearInputs();
    endtask

    task automatic streamBackToBack();
        issue(randomReg(), randomReg(), '0, 1'b0);
        for (int i = 0; i < 20; i++) begin
            nextCycle();
            checkNoTrap('0);
            if (i < 19) issue(randomReg(), randomReg(), '0, 1'b0);
        end
        clearInputs();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        clearInputs();
        for (int i = 0; i < `REG_COUNT; i++) regModel[i] = '0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        checkCleared();
        readRegisters();
        readCsrs();
        trapIllegalCsr();
        holdOnStall();
        clearOnFlush();
        streamBackToBack();
        nextCycle();
        errors = errors + regReadTop_i.regReadStage_i.regReadStageAssert_i.failCount;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end
        else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: sim/regReadTb_assert.sv
// stage assertions sampled at the rising edge, they assume stall and flush stay low during reset
`include "core_defines.svh"

module regReadStageAssert (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic flush,
    input logic inTrapValid,
    input coreTypes::excCode_t inTrapCause,
    input logic outValid,
    input coreTypes::opKind_t outOp,
    input coreTypes::word_t outPc,
    input coreTypes::word_t outInsn,
    input coreTypes::csrAddr_t outCsrAddr,
    input coreTypes::word_t outSrcCsrValue,
    input coreTypes::regAddr_t outSrcRegAddr1,
    input coreTypes::regAddr_t outSrcRegAddr2,
    input coreTypes::regAddr_t outDstRegAddr,
    input coreTypes::word_t outSrcRegValue1,
    input coreTypes::word_t outSrcRegValue2,
    input logic outTrapValid,
    input coreTypes::excCode_t outTrapCause,
    input coreTypes::word_t outTrapValue
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int OutWidth = 6 * `XLEN + 36; // six words plus the narrow fields

    logic [OutWidth-1:0] allOutputs;
    int failCount = 0; // read by the testbench at the end of the run

    assign allOutputs = {outValid, outOp, outPc, outInsn, outCsrAddr, outSrcCsrValue,
        outSrcRegAddr1, outSrcRegAddr2, outDstRegAddr, outSrcRegValue1, outSrcRegValue2,
        outTrapValid, outTrapCause, outTrapValue};

    resetClears: assert property (@(posedge clk) rst |=> allOutputs == '0)
        else begin $error("stage outputs not zero after reset"); failCount++; end

    flushDropsValid: assert property (@(posedge clk) flush |=> !outValid)
        else begin $error("outValid still high after flush"); failCount++; end

    // the stage register must not move while stalled
    stallHolds: assert property (@(posedge clk) (stall && !flush && !rst) |=> $stable(allOutputs))
        else begin $error("stage outputs changed under stall"); failCount++; end

    trapCausePasses: assert property (@(posedge clk)
        (inTrapValid && !stall && !flush && !rst) |=>
        (outTrapValid && outTrapCause == $past(inTrapCause)))
        else begin $error("incoming trap cause was not passed on"); failCount++; end

endmodule

bind regReadStage regReadStageAssert regReadStageAssert_i (.*);

// File: src/coreTypes.sv
// shared core types, widths follow core_defines.svh and the enum codes follow the RV32 privileged spec
`include "core_defines.svh"

package coreTypes;

    // one data word, also used for pc and raw instruction bits
    typedef logic [`XLEN-1:0] word_t;

    // general register index, 5 bits for 32 registers
    typedef logic [$clog2(`REG_COUNT)-1:0] regAddr_t;

    // CSR address as encoded in the instruction
    typedef logic [`CSR_ADDR_WIDTH-1:0] csrAddr_t;

    // the subset of synchronous exception codes that the front end can raise
    typedef enum logic [3:0] {
        InsnMisaligned = 4'd0,
        IllegalInsn = 4'd2,
        Breakpoint = 4'd3,
        Ecall = 4'd11
    } excCode_t;

    // operation class from decode, carried through to execute untouched
    typedef enum logic [2:0] {
        OpAlu = 3'd0,
        OpLoad = 3'd1,
        OpStore = 3'd2,
        OpBranch = 3'd3,
        OpCsr = 3'd4,
        OpSystem = 3'd5
    } opKind_t;

endpackage

// File: src/core_defines.svh
// widths and CSR map for an RV32 core, machine mode only, single hart (mhartid is zero)
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data path width, RV32 only
`define XLEN 32

// number of general registers, x0 included
`define REG_COUNT 32

// CSR address space of the Zicsr encoding
`define CSR_ADDR_WIDTH 12

// implemented machine CSRs
`define CSR_MSCRATCH 12'h340
`define CSR_MTVEC 12'h305
`define CSR_MEPC 12'h341
`define CSR_MCAUSE 12'h342
`define CSR_MHARTID 12'hF14

`endif

// File: src/csrFile.sv
// machine-mode CSRs without side effects, no privilege checks and no read-only-address write trap
`include "core_defines.svh"

module csrFile (
    input logic clk,
    input logic rst,

    input coreTypes::csrAddr_t readAddr,
    input logic readEnable,
    output coreTypes::word_t readValue,
    output logic readIllegal,

    input logic writeEnable,
    input coreTypes::csrAddr_t writeAddr,
    input coreTypes::word_t writeData
);

    coreTypes::word_t mscratch;
    coreTypes::word_t mtvec;
    coreTypes::word_t mepc;
    coreTypes::word_t mcause;

    logic readKnown;
    coreTypes::word_t decodedValue;

    // address decode against the implemented set
    always_comb begin
        readKnown = 1'b1;
        decodedValue = '0;
        case (readAddr)
            `CSR_MSCRATCH: decodedValue = mscratch;
            `CSR_MTVEC: decodedValue = mtvec;
            `CSR_MEPC: decodedValue = mepc;
            `CSR_MCAUSE: decodedValue = mcause;
            `CSR_MHARTID: decodedValue = '0; // single hart, id zero
            default: readKnown = 1'b0;
        endcase
    end

    // a disabled read never flags, whatever the address holds
    always_comb begin
        readIllegal = readEnable && !readKnown;
        readValue = (readEnable && readKnown) ? decodedValue : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mscratch <= '0;
            mtvec <= '0;
            mepc <= '0;
            mcause <= '0;
        end
        else if (writeEnable) begin
            case (writeAddr)
                `CSR_MSCRATCH: mscratch <= writeData;
                `CSR_MTVEC: mtvec <= writeData;
                `CSR_MEPC: mepc <= writeData;
                `CSR_MCAUSE: mcause <= writeData;
                default: ; // mhartid and unknown addresses keep nothing
            endcase
        end
    end

endmodule

// File: src/regFile.sv
// general register file, two asynchronous reads and one write, reads see the old value during a write
`include "core_defines.svh"

module regFile (
    input logic clk,
    input logic rst,

    input coreTypes::regAddr_t readAddr1,
    input coreTypes::regAddr_t readAddr2,
    output coreTypes::word_t readValue1,
    output coreTypes::word_t readValue2,

    input logic writeEnable,
    input coreTypes::regAddr_t writeAddr,
    input coreTypes::word_t writeData
);

    coreTypes::word_t regs [`REG_COUNT];

    // x0 is hardwired, so its entry is never consulted
    always_comb begin
        readValue1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
        readValue2 = (readAddr2 == '0) ? '0 : regs[readAddr2];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0; // whole array starts from zero
            end
        end
        else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData; // writes to x0 are dropped
        end
    end

endmodule

// File: src/regReadStage.sv
// one cycle of latency and the sender must hold the inputs while stall is high
module regReadStage (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic flush,

    // decode side
    input logic inValid,
    input coreTypes::opKind_t inOp,
    input logic inCsrReadEnable,
    input coreTypes::word_t inPc,
    input coreTypes::word_t inInsn,
    input coreTypes::csrAddr_t inCsrAddr,
    input coreTypes::regAddr_t inSrcRegAddr1,
    input coreTypes::regAddr_t inSrcRegAddr2,
    input coreTypes::regAddr_t inDstRegAddr,
    input logic inTrapValid,
    input coreTypes::excCode_t inTrapCause,
    input coreTypes::word_t inTrapValue,

    // register file and CSR file read ports
    output coreTypes::regAddr_t regReadAddr1,
    output coreTypes::regAddr_t regReadAddr2,
    input coreTypes::word_t regReadValue1,
    input coreTypes::word_t regReadValue2,
    output coreTypes::csrAddr_t csrReadAddr,
    output logic csrReadEnable,
    input coreTypes::word_t csrReadValue,
    input logic csrReadIllegal,

    // execute side
    output logic outValid,
    output coreTypes::opKind_t outOp,
    output coreTypes::word_t outPc,
    output coreTypes::word_t outInsn,
    output coreTypes::csrAddr_t outCsrAddr,
    output coreTypes::word_t outSrcCsrValue,
    output coreTypes::regAddr_t outSrcRegAddr1,
    output coreTypes::regAddr_t outSrcRegAddr2,
    output coreTypes::regAddr_t outDstRegAddr,
    output coreTypes::word_t outSrcRegValue1,
    output coreTypes::word_t outSrcRegValue2,
    output logic outTrapValid,
    output coreTypes::excCode_t outTrapCause,
    output coreTypes::word_t outTrapValue
);

    logic nextTrapValid;
    coreTypes::excCode_t nextTrapCause;
    coreTypes::word_t nextTrapValue;

    always_comb begin
        regReadAddr1 = inSrcRegAddr1;
        regReadAddr2 = inSrcRegAddr2;
        csrReadAddr = inCsrAddr;
        csrReadEnable = inCsrReadEnable;
    end

    // an earlier trap wins over the CSR illegality found here
    always_comb begin
        if (inTrapValid) begin
            nextTrapValid = 1'b1;
            nextTrapCause = inTrapCause;
            nextTrapValue = inTrapValue;
        end
        else if (csrReadIllegal) begin
            nextTrapValid = 1'b1;
            nextTrapCause = coreTypes::IllegalInsn;
            nextTrapValue = inInsn; // mtval gets the faulting instruction bits
        end
        else begin
            nextTrapValid = 1'b0;
            nextTrapCause = coreTypes::excCode_t'(4'd0); // no trap leaves the fields zero
            nextTrapValue = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin // flush outranks stall
            outValid <= 1'b0;
            outOp <= coreTypes::opKind_t'(3'd0);
            outPc <= '0;
            outInsn <= '0;
            outCsrAddr <= '0;
            outSrcCsrValue <= '0;
            outSrcRegAddr1 <= '0;
            outSrcRegAddr2 <= '0;
            outDstRegAddr <= '0;
            outSrcRegValue1 <= '0;
            outSrcRegValue2 <= '0;
            outTrapValid <= 1'b0;
            outTrapCause <= coreTypes::excCode_t'(4'd0);
            outTrapValue <= '0;
        end
        else if (!stall) begin // under stall every field keeps its value
            outValid <= inValid;
            outOp <= inOp;
            outPc <= inPc;
            outInsn <= inInsn;
            outCsrAddr <= inCsrAddr;
            outSrcCsrValue <= csrReadValue;
            outSrcRegAddr1 <= inSrcRegAddr1;
            outSrcRegAddr2 <= inSrcRegAddr2;
            outDstRegAddr <= inDstRegAddr;
            outSrcRegValue1 <= regReadValue1;
            outSrcRegValue2 <= regReadValue2;
            outTrapValid <= nextTrapValid;
            outTrapCause <= nextTrapCause;
            outTrapValue <= nextTrapValue;
        end
    end

endmodule

// File: src/regReadTop.sv
// register-read subsystem, stall and flush come from an outside controller and writeback owns the write ports
module regReadTop (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic flush,

    input logic inValid,
    input coreTypes::opKind_t inOp,
    input logic inCsrReadEnable,
    input coreTypes::word_t inPc,
    input coreTypes::word_t inInsn,
    input coreTypes::csrAddr_t inCsrAddr,
    input coreTypes::regAddr_t inSrcRegAddr1,
    input coreTypes::regAddr_t inSrcRegAddr2,
    input coreTypes::regAddr_t inDstRegAddr,
    input logic inTrapValid,
    input coreTypes::excCode_t inTrapCause,
    input coreTypes::word_t inTrapValue,

    // writeback side
    input logic regWriteEnable,
    input coreTypes::regAddr_t regWriteAddr,
    input coreTypes::word_t regWriteData,
    input logic csrWriteEnable,
    input coreTypes::csrAddr_t csrWriteAddr,
    input coreTypes::word_t csrWriteData,

    output logic outValid,
    output coreTypes::opKind_t outOp,
    output coreTypes::word_t outPc,
    output coreTypes::word_t outInsn,
    output coreTypes::csrAddr_t outCsrAddr,
    output coreTypes::word_t outSrcCsrValue,
    output coreTypes::regAddr_t outSrcRegAddr1,
    output coreTypes::regAddr_t outSrcRegAddr2,
    output coreTypes::regAddr_t outDstRegAddr,
    output coreTypes::word_t outSrcRegValue1,
    output coreTypes::word_t outSrcRegValue2,
    output logic outTrapValid,
    output coreTypes::excCode_t outTrapCause,
    output coreTypes::word_t outTrapValue
);

    coreTypes::regAddr_t regReadAddr1, regReadAddr2;
    coreTypes::word_t regReadValue1, regReadValue2;
    coreTypes::csrAddr_t csrReadAddr;
    logic csrReadEnable, csrReadIllegal;
    coreTypes::word_t csrReadValue;

    regReadStage regReadStage_i (.*); // port names match the nets one to one

    regFile regFile_i (
        .clk, .rst,
        .readAddr1(regReadAddr1), .readAddr2(regReadAddr2),
        .readValue1(regReadValue1), .readValue2(regReadValue2),
        .writeEnable(regWriteEnable), .writeAddr(regWriteAddr), .writeData(regWriteData)
    );

    csrFile csrFile_i (
        .clk, .rst,
        .readAddr(csrReadAddr), .readEnable(csrReadEnable),
        .readValue(csrReadValue), .readIllegal(csrReadIllegal),
        .writeEnable(csrWriteEnable), .writeAddr(csrWriteAddr), .writeData(csrWriteData)
    );

endmodule
